// ==== rtl/sadAbsDiff.sv ====
`timescale 1ns/1ps
`default_nettype none

module sadAbsDiff (
    input wire sadPkg::sadPairsT pairs,
    output sadPkg::sadDiffsT diffs
);

    localparam int sw = sadPkg::sampleWidth;

    // One comparator and subtractor per lane
    for (genvar i = 0; i < sadPkg::laneCount; i++) begin : gLane
        logic [sw-1:0] curSample;
        logic [sw-1:0] refSample;
        logic curLarger;

        assign curSample = pairs[i][2*sw-1:sw];
        assign refSample = pairs[i][sw-1:0];

        // Unsigned compare
        assign curLarger = curSample > refSample;

        assign diffs[i] = curLarger ? (curSample - refSample)
                                    : (refSample - curSample);
    end

endmodule

`default_nettype wire

// ==== rtl/sadAdderTree.sv ====
`timescale 1ns/1ps
`default_nettype none

module sadAdderTree (
    input wire sadPkg::sadDiffsT diffs,
    output logic [sadPkg::sumWidth-1:0] sum
);

    localparam int sw = sadPkg::sampleWidth;
    localparam int n = sadPkg::laneCount;

    // Each level grows by one bit
    logic [n/2-1:0][sw:0] lvl1;
    logic [n/4-1:0][sw+1:0] lvl2;
    logic [n/8-1:0][sw+2:0] lvl3;

    //////////////////////////////
    // Level 1, 16 to 8
    //////////////////////////////
    for (genvar i = 0; i < n/2; i++) begin : gLvl1
        assign lvl1[i] = {1'b0, diffs[2*i]} + {1'b0, diffs[2*i+1]};
    end

    //////////////////////////////
    // Level 2, 8 to 4
    //////////////////////////////
    for (genvar i = 0; i < n/4; i++) begin : gLvl2
        assign lvl2[i] = {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
    end

    //////////////////////////////
    // Level 3, 4 to 2
    //////////////////////////////
    for (genvar i = 0; i < n/8; i++) begin : gLvl3
        assign lvl3[i] = {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
    end

    // Final level, 2 to 1
    assign sum = {1'b0, lvl3[0]} + {1'b0, lvl3[1]};

endmodule

`default_nettype wire

// ==== rtl/sadPkg.sv ====
`default_nettype none

package sadPkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Sample pairs per SAD instruction
    localparam int laneCount = 16;
    localparam int sampleWidth = 16;
    // 16 lanes of 16-bit differences need 4 extra bits
    localparam int sumWidth = 20;

    // SAD instruction encoding, SPECIAL2 style R-type
    localparam logic [5:0] sadOpcode = 6'b011100;
    localparam logic [5:0] sadFunct = 6'b111010;

    //////////////////////////////
    // Bundle types
    //////////////////////////////

    typedef struct packed {
        logic memToReg;
        logic regWrite;
        logic [4:0] writeReg;
        logic jal;
        logic display;
        logic branch;
        logic [1:0] branchType;
    } sadCtrlT;

    typedef struct packed {
        logic [31:0] memReadData;
        logic [31:0] aluResult;
        logic [31:0] pcPlus4;
        logic [31:0] instruction;
    } sadDataT;

    // Upper half current sample, lower half reference sample
    typedef logic [laneCount-1:0][31:0] sadPairsT;
    typedef logic [laneCount-1:0][sampleWidth-1:0] sadDiffsT;

    // Payloads carried by the three stage registers
    typedef struct packed {
        sadDataT data;
        sadPairsT pairs;
    } stageAT;

    typedef struct packed {
        sadDataT data;
        sadDiffsT diffs;
    } stageBT;

    typedef struct packed {
        sadDataT data;
        logic [sumWidth-1:0] sum;
    } stageCT;

endpackage

`default_nettype wire

// ==== rtl/sadStageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module sadStageReg #(
    parameter type payloadT = sadPkg::stageAT
) (
    input wire logic Clk,
    input wire logic rstN,
    input wire logic flush,
    input wire sadPkg::sadCtrlT ctrlIn,
    input wire payloadT payloadIn,
    output sadPkg::sadCtrlT ctrlOut,
    output payloadT payloadOut
);

    //////////////////////////////
    // Control path
    //////////////////////////////

    // Flush turns the captured bundle into a bubble
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ctrlOut <= '0;
        end else if (flush) begin
            ctrlOut <= '0;
        end else begin
            ctrlOut <= ctrlIn;
        end
    end

    //////////////////////////////
    // Payload path
    //////////////////////////////

    // Data keeps moving, even under flush
    always_ff @(posedge Clk) begin
        payloadOut <= payloadIn;
    end

endmodule

`default_nettype wire

// ==== rtl/sadTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sadTop (
    input wire logic Clk,
    input wire logic rstN,
    input wire logic flush,
    input wire sadPkg::sadCtrlT ctrlIn,
    input wire sadPkg::sadDataT dataIn,
    input wire sadPkg::sadPairsT pairsIn,
    output logic regWriteEn,
    output logic [4:0] writeReg,
    output logic [31:0] writeData,
    output logic displayEn,
    output logic branch,
    output logic [1:0] branchType
);

    sadPkg::sadCtrlT ctrlA;
    sadPkg::sadCtrlT ctrlB;
    sadPkg::sadCtrlT ctrlC;

    sadPkg::stageAT stageAIn;
    sadPkg::stageAT stageA;
    sadPkg::stageBT stageBIn;
    sadPkg::stageBT stageB;
    sadPkg::stageCT stageCIn;
    sadPkg::stageCT stageC;

    sadPkg::sadDiffsT diffs;
    logic [sadPkg::sumWidth-1:0] sum;

    //////////////////////////////
    // Stage A, absolute differences
    //////////////////////////////
    assign stageAIn = '{data: dataIn, pairs: pairsIn};

    sadStageReg #(.payloadT(sadPkg::stageAT)) regA (
        .Clk(Clk),
        .rstN(rstN),
        .flush(flush),
        .ctrlIn(ctrlIn),
        .payloadIn(stageAIn),
        .ctrlOut(ctrlA),
        .payloadOut(stageA)
    );

    sadAbsDiff absDiff (
        .pairs(stageA.pairs),
        .diffs(diffs)
    );

    //////////////////////////////
    // Stage B, sum
    //////////////////////////////
    assign stageBIn = '{data: stageA.data, diffs: diffs};

    sadStageReg #(.payloadT(sadPkg::stageBT)) regB (
        .Clk(Clk),
        .rstN(rstN),
        .flush(flush),
        .ctrlIn(ctrlA),
        .payloadIn(stageBIn),
        .ctrlOut(ctrlB),
        .payloadOut(stageB)
    );

    sadAdderTree adderTree (
        .diffs(stageB.diffs),
        .sum(sum)
    );

    //////////////////////////////
    // Stage C, writeback
    //////////////////////////////
    assign stageCIn = '{data: stageB.data, sum: sum};

    sadStageReg #(.payloadT(sadPkg::stageCT)) regC (
        .Clk(Clk),
        .rstN(rstN),
        .flush(flush),
        .ctrlIn(ctrlB),
        .payloadIn(stageCIn),
        .ctrlOut(ctrlC),
        .payloadOut(stageC)
    );

    sadWriteback writeback (
        .ctrl(ctrlC),
        .stage(stageC),
        .regWriteEn(regWriteEn),
        .writeReg(writeReg),
        .writeData(writeData),
        .displayEn(displayEn),
        .branch(branch),
        .branchType(branchType)
    );

endmodule

`default_nettype wire

// ==== rtl/sadWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

module sadWriteback (
    input wire sadPkg::sadCtrlT ctrl,
    input wire sadPkg::stageCT stage,
    output logic regWriteEn,
    output logic [4:0] writeReg,
    output logic [31:0] writeData,
    output logic displayEn,
    output logic branch,
    output logic [1:0] branchType
);

    logic isSad;
    logic [31:0] sumWord;

    // Opcode in [31:26], funct in [5:0]
    assign isSad = (stage.data.instruction[31:26] == sadPkg::sadOpcode) &&
                   (stage.data.instruction[5:0] == sadPkg::sadFunct);

    assign sumWord = {{(32 - sadPkg::sumWidth){1'b0}}, stage.sum};

    //////////////////////////////
    // Write data select
    //////////////////////////////

    // jal beats memToReg, which beats SAD
    always_comb begin
        if (ctrl.jal) begin
            writeData = stage.data.pcPlus4;
        end else if (ctrl.memToReg) begin
            writeData = stage.data.memReadData;
        end else if (isSad) begin
            writeData = sumWord;
        end else begin
            writeData = stage.data.aluResult;
        end
    end

    // Register file and branch controls
    assign regWriteEn = ctrl.regWrite;
    assign writeReg = ctrl.writeReg;
    assign displayEn = ctrl.display;
    assign branch = ctrl.branch;
    assign branchType = ctrl.branchType;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the SAD pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module sadTb --Mdir obj_dir -o sadSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sadSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1

// ==== testbench/sadTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sadTb;

    localparam int waitLimit = 20;
    localparam int pipeEdges = 3;

    logic Clk;
    logic rstN;
    logic flush;
    sadPkg::sadCtrlT ctrlIn;
    sadPkg::sadDataT dataIn;
    sadPkg::sadPairsT pairsIn;
    logic regWriteEn;
    logic [4:0] writeReg;
    logic [31:0] writeData;
    logic displayEn;
    logic branch;
    logic [1:0] branchType;

    string testName;
    int testErrStart;
    int testCount = 0;
    int failedTests = 0;
    int checkCount = 0;
    int errorCount = 0;

    sadTop i_dut (
        .Clk(Clk),
        .rstN(rstN),
        .flush(flush),
        .ctrlIn(ctrlIn),
        .dataIn(dataIn),
        .pairsIn(pairsIn),
        .regWriteEn(regWriteEn),
        .writeReg(writeReg),
        .writeData(writeData),
        .displayEn(displayEn),
        .branch(branch),
        .branchType(branchType)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Sum of |current - reference| over all lanes
    function automatic logic [31:0] sadModel(input sadPkg::sadPairsT pairs);
        int total;
        int diff;
        total = 0;
        for (int i = 0; i < sadPkg::laneCount; i++) begin
            diff = int'(pairs[i][31:16]) - int'(pairs[i][15:0]);
            total += (diff < 0) ? -diff : diff;
        end
        return 32'(total);
    endfunction

    function automatic sadPkg::sadPairsT randomPairs();
        sadPkg::sadPairsT pairs;
        for (int i = 0; i < sadPkg::laneCount; i++) begin
            pairs[i] = $urandom;
        end
        return pairs;
    endfunction

    // R-type add unless a SAD instruction is asked for
    function automatic sadPkg::sadDataT randomData(input logic isSad);
        sadPkg::sadDataT d;
        d.memReadData = $urandom;
        d.aluResult = $urandom;
        d.pcPlus4 = $urandom;
        if (isSad) begin
            d.instruction = {sadPkg::sadOpcode, 20'($urandom), sadPkg::sadFunct};
        end else begin
            d.instruction = {6'b000000, 20'($urandom), 6'b100000};
        end
        return d;
    endfunction

    //////////////////////////////
    // Checks and reporting
    //////////////////////////////

    task automatic checkData(input logic [31:0] exp);
        checkCount++;
        if (writeData !== exp) begin
            errorCount++;
            $display("ERR %s writeData: expected %h, actual %h", testName, exp, writeData);
        end
    endtask

    // memToReg and jal are not visible at the outputs
    task automatic checkCtrl(input sadPkg::sadCtrlT exp);
        sadPkg::sadCtrlT act;
        act = '0;
        act.regWrite = regWriteEn;
        act.writeReg = writeReg;
        act.display = displayEn;
        act.branch = branch;
        act.branchType = branchType;
        exp.memToReg = 1'b0;
        exp.jal = 1'b0;
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("ERR %s ctrl: expected %h, actual %h", testName, exp, act);
        end
    endtask

    task automatic checkLatency(input int edges);
        checkCount++;
        if (edges != pipeEdges) begin
            errorCount++;
            $display("ERR %s latency: expected %0d, actual %0d", testName, pipeEdges, edges);
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrStart = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        if (errorCount == testErrStart) begin
            $display("test %s: ok", testName);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", testName, errorCount - testErrStart);
        end
    endtask

    //////////////////////////////
    // Drive and wait
    //////////////////////////////

    task automatic applyInputs(input sadPkg::sadCtrlT ctrl, input sadPkg::sadDataT data,
                               input sadPkg::sadPairsT pairs);
        ctrlIn = ctrl;
        dataIn = data;
        pairsIn = pairs;
    endtask

    // Counts edges until a register write shows up; inputs go idle after the first
    task automatic waitForWrite(output int edges);
        edges = 0;
        do begin
            @(negedge Clk);
            edges++;
            ctrlIn = '0;
        end while (!regWriteEn && edges < waitLimit);
        if (!regWriteEn) begin
            $display("%s: no register write appeared within %0d cycles", testName, waitLimit);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic drain();
        @(negedge Clk);
        ctrlIn = '0;
        repeat (pipeEdges) @(negedge Clk);
    endtask

    // One bundle through the pipeline, then checked
    task automatic runSingle(input sadPkg::sadCtrlT ctrl, input sadPkg::sadDataT data,
                             input sadPkg::sadPairsT pairs, input logic [31:0] expData);
        int edges;
        @(negedge Clk);
        applyInputs(ctrl, data, pairs);
        waitForWrite(edges);
        checkLatency(edges);
        checkCtrl(ctrl);
        checkData(expData);
        drain();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic resetTest();
        beginTest("reset");
        for (int i = 0; i < 3; i++) begin
            checkCtrl('0);
            @(negedge Clk);
        end
        endTest();
    endtask

    task automatic aluTest();
        sadPkg::sadCtrlT ctrl;
        sadPkg::sadDataT data;
        beginTest("alu");
        ctrl = '0;
        ctrl.regWrite = 1'b1;
        ctrl.writeReg = 5'($urandom_range(31, 1));
        ctrl.branch = 1'b1;
        ctrl.branchType = 2'($urandom);
        data = randomData(1'b0);
        runSingle(ctrl, data, randomPairs(), data.aluResult);
        endTest();
    endtask

    task automatic priorityTest();
        sadPkg::sadCtrlT ctrl;
        sadPkg::sadDataT data;
        beginTest("priority");
        ctrl = '0;
        ctrl.regWrite = 1'b1;
        ctrl.writeReg = 5'd7;
        ctrl.memToReg = 1'b1;
        // Load data wins over a SAD encoding
        data = randomData(1'b1);
        runSingle(ctrl, data, randomPairs(), data.memReadData);
        ctrl.jal = 1'b1;
        ctrl.writeReg = 5'd31;
        data = randomData(1'b0);
        runSingle(ctrl, data, randomPairs(), data.pcPlus4);
        endTest();
    endtask

    task automatic sadTest();
        sadPkg::sadCtrlT ctrl;
        sadPkg::sadDataT data;
        sadPkg::sadPairsT pairs;
        beginTest("sad");
        ctrl = '0;
        ctrl.regWrite = 1'b1;
        ctrl.display = 1'b1;
        ctrl.writeReg = 5'd12;
        data = randomData(1'b1);
        pairs = randomPairs();
        runSingle(ctrl, data, pairs, sadModel(pairs));
        for (int i = 0; i < sadPkg::laneCount; i++) begin
            pairs[i][15:0] = 16'($urandom);
            pairs[i][31:16] = pairs[i][15:0];
        end
        runSingle(ctrl, data, pairs, 32'd0);
        // Full-scale difference in every lane, both directions
        for (int i = 0; i < sadPkg::laneCount; i++) begin
            pairs[i] = (i % 2 == 1) ? {16'hffff, 16'h0000} : {16'h0000, 16'hffff};
        end
        runSingle(ctrl, data, pairs, 32'h000ffff0);
        endTest();
    endtask

    task automatic pipelineTest();
        sadPkg::sadCtrlT ctrlQ[5];
        sadPkg::sadDataT dataQ[5];
        sadPkg::sadPairsT pairsQ[5];
        logic [31:0] expQ[5];
        beginTest("pipeline");
        for (int i = 0; i < 5; i++) begin
            ctrlQ[i] = '0;
            ctrlQ[i].regWrite = 1'b1;
            ctrlQ[i].writeReg = 5'(i + 1);
            dataQ[i] = randomData(i % 2 == 1);
            pairsQ[i] = randomPairs();
            expQ[i] = (i % 2 == 1) ? sadModel(pairsQ[i]) : dataQ[i].aluResult;
        end
        ctrlQ[2].memToReg = 1'b1;
        expQ[2] = dataQ[2].memReadData;
        ctrlQ[4].jal = 1'b1;
        expQ[4] = dataQ[4].pcPlus4;
        // Outputs are sampled before the next bundle is driven
        for (int step = 0; step < 5 + pipeEdges; step++) begin
            @(negedge Clk);
            if (step >= pipeEdges) begin
                checkCtrl(ctrlQ[step - pipeEdges]);
                checkData(expQ[step - pipeEdges]);
            end else begin
                checkCtrl('0);
            end
            if (step < 5) begin
                applyInputs(ctrlQ[step], dataQ[step], pairsQ[step]);
            end else begin
                ctrlIn = '0;
            end
        end
        drain();
        endTest();
    endtask

    task automatic flushTest();
        sadPkg::sadCtrlT ctrl;
        sadPkg::sadDataT data;
        beginTest("flush");
        ctrl = '0;
        ctrl.regWrite = 1'b1;
        ctrl.display = 1'b1;
        ctrl.writeReg = 5'd9;
        // Flush rides with the third bundle
        for (int i = 0; i < 3; i++) begin
            @(negedge Clk);
            checkCtrl('0);
            applyInputs(ctrl, randomData(i == 1), randomPairs());
            flush = (i == 2);
        end
        for (int i = 0; i < pipeEdges + 2; i++) begin
            @(negedge Clk);
            ctrlIn = '0;
            flush = 1'b0;
            checkCtrl('0);
        end
        data = randomData(1'b0);
        runSingle(ctrl, data, randomPairs(), data.aluResult);
        endTest();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(28));
        rstN = 1'b0;
        flush = 1'b0;
        // Busy controls while in reset, only the clear keeps the outputs low
        ctrlIn = '1;
        dataIn = '0;
        pairsIn = '0;
        repeat (4) @(negedge Clk);
        rstN = 1'b1;
        ctrlIn = '0;

        resetTest();
        aluTest();
        priorityTest();
        sadTest();
        pipelineTest();
        flushTest();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/sadPkg.sv
rtl/sadStageReg.sv
rtl/sadAbsDiff.sv
rtl/sadAdderTree.sv
rtl/sadWriteback.sv
rtl/sadTop.sv
testbench/sadTb.sv
